// File: Makefile
# Verilator build and run of the cipher testbench
# override any variable on the command line, e.g. make sim LOG=run.log

VERILATOR ?= verilator
TOP       ?= tb_rst_cipher
FILELIST  ?= vlog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "Done: errors found" $(LOG); then \
		echo "simulation reported failure"; \
		exit 1; \
	fi
	@if ! grep -q "Done: no errors" $(LOG); then \
		echo "simulation ended without a result line"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: include/rst_model.svh
//********************************************************************
// reference model for the testbench: key check, table installation,
// rotation and character encoding
//********************************************************************

`ifndef RST_MODEL_SVH
`define RST_MODEL_SVH

// plain ASCII range test
function automatic bit model_char_ok(input rst_pkg::char_t c);
  return (c >= 8'h30 && c <= 8'h39) ||
         (c >= 8'h41 && c <= 8'h5a) ||
         (c >= 8'h61 && c <= 8'h7a);
endfunction

function automatic bit model_key_ok(input rst_pkg::key_t key);
  bit ok;
  ok = 1'b1;
  for (int i = 0; i < 12; i++) begin
    if (!model_char_ok(key[i])) begin
      ok = 1'b0;
    end
    for (int j = 0; j < i; j++) begin
      if (key[i] == key[j]) begin
        ok = 1'b0;
      end
    end
  end
  return ok;
endfunction

function automatic rst_pkg::sub_table_t model_install(input rst_pkg::key_t key);
  int                  row_pos[6] = '{11, 1, 9, 3, 7, 5};
  int                  col_pos[6] = '{10, 0, 8, 2, 6, 4};
  rst_pkg::sub_table_t t;
  for (int i = 0; i < 6; i++) begin
    t.rows[i] = key[row_pos[i]];
    t.cols[i] = key[col_pos[i]];
  end
  return t;
endfunction

function automatic rst_pkg::sub_table_t model_rotate(input rst_pkg::sub_table_t t);
  rst_pkg::sub_table_t r;
  for (int i = 0; i < 6; i++) begin
    r.rows[(i + 1) % 6] = t.rows[i];
    r.cols[(i + 1) % 6] = t.cols[i];
  end
  return r;
endfunction

// position in the 36-symbol alphabet gives row and column
function automatic rst_pkg::ctxt_t model_encode(input rst_pkg::sub_table_t t,
                                                input rst_pkg::char_t     c);
  string          alphabet = "abcdefghijklmnopqrstuvwxyz0123456789";
  rst_pkg::char_t lc;
  rst_pkg::ctxt_t res;
  res = '0;
  lc  = (c >= 8'h41 && c <= 8'h5a) ? c + 8'h20 : c;
  for (int p = 0; p < 36; p++) begin
    if (alphabet[p] == lc) begin
      res.row = t.rows[p / 6];
      res.col = t.cols[p % 6];
    end
  end
  return res;
endfunction

`endif

// File: bench/tb_rst_cipher.sv
//**********************************************************************
// testbench for the cipher top level: clock, reset, LCG, directed
// tests for key check, installation, encoding and rotation, and the
// random character stream
//**********************************************************************

module tb_rst_cipher;

  timeunit 1ns;
  timeprecision 100ps;

  import rst_pkg::*;

  `include "rst_model.svh"

  logic  clk;
  logic  rst_n;
  logic  ptxt_valid;
  key_t  key;
  char_t ptxt_char;
  ctxt_t ctxt_str;
  logic  ctxt_ready;
  logic  err_invalid_ptxt_char;
  logic  err_invalid_key;
  logic  key_not_installed;

  sub_table_t  m_table;
  bit          m_installed;
  int          errors;
  int          checks;
  logic [31:0] rng;

  rst_cipher u_rst_cipher (
    .clk                   (clk),
    .rst_n                 (rst_n),
    .ptxt_valid            (ptxt_valid),
    .key                   (key),
    .ptxt_char             (ptxt_char),
    .ctxt_str              (ctxt_str),
    .ctxt_ready            (ctxt_ready),
    .err_invalid_ptxt_char (err_invalid_ptxt_char),
    .err_invalid_key       (err_invalid_key),
    .key_not_installed     (key_not_installed)
  );

  always #10 clk = ~clk;

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic key_t make_key(input string s);
    key_t k;
    for (int i = 0; i < 12; i++) begin
      k[i] = s[i];
    end
    return k;
  endfunction

  task automatic compare_bit(input string name, input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Fail %0t %s: got %b expected %b", $time, name, got, exp);
    end
  endtask

  task automatic compare_ctxt(input string name, input ctxt_t got, input ctxt_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Fail %0t %s: got %h expected %h", $time, name, got, exp);
    end
  endtask

  // compare every output with the model and step it
  task automatic check_cycle();
    ctxt_t exp_ctxt;
    bit    exp_ready;
    bit    exp_err_char;
    bit    exp_err_key;
    exp_err_key  = !model_key_ok(key);
    exp_err_char = !model_char_ok(ptxt_char);
    exp_ready    = ptxt_valid && !exp_err_char && m_installed;
    exp_ctxt     = exp_ready ? model_encode(m_table, ptxt_char) : '0;
    compare_bit("err_invalid_key", err_invalid_key, exp_err_key);
    compare_bit("err_invalid_ptxt_char", err_invalid_ptxt_char, exp_err_char);
    compare_bit("key_not_installed", key_not_installed, !m_installed);
    compare_bit("ctxt_ready", ctxt_ready, exp_ready);
    compare_ctxt("ctxt_str", ctxt_str, exp_ctxt);
    if (!m_installed) begin
      if (!exp_err_key) begin
        m_table     = model_install(key);
        m_installed = 1'b1;
      end
    end else if (exp_ready) begin
      m_table = model_rotate(m_table);
    end
  endtask

  // exp_ready below zero means the model alone decides
  task automatic send_char(input char_t c, input bit valid, input int exp_ready);
    ptxt_char  = c;
    ptxt_valid = valid;
    #16;
    if (exp_ready >= 0) begin
      compare_bit("ctxt_ready", ctxt_ready, exp_ready[0]);
    end
    check_cycle();
    @(posedge clk);
    #2;
  endtask

  task automatic send_string(input string s, input int exp_ready);
    for (int i = 0; i < s.len(); i++) begin
      send_char(s[i], 1'b1, exp_ready);
    end
    ptxt_valid = 1'b0;
  endtask

  task automatic apply_reset();
    ptxt_valid  = 1'b0;
    ptxt_char   = '0;
    rst_n       = 1'b0;
    repeat (8) @(posedge clk);
    #2;
    rst_n       = 1'b1;
    m_table     = '0;
    m_installed = 1'b0;
  endtask

  task automatic install_key(input string s);
    int n;
    n   = 0;
    key = make_key(s);
    while (key_not_installed && n < 4) begin
      send_char(8'h00, 1'b0, 0);
      n++;
    end
    if (key_not_installed) begin
      errors++;
      $display("timeout at %0t: key %s was never installed", $time, s);
    end else if (n != 1) begin
      errors++;
      $display("key_not_installed fell after %0d edges instead of one", n);
    end
  endtask

  task automatic test_reset_state();
    key = '0;
    apply_reset();
    compare_bit("key_not_installed", key_not_installed, 1'b1);
    compare_bit("err_invalid_key", err_invalid_key, 1'b1);
    compare_bit("ctxt_ready", ctxt_ready, 1'b0);
    compare_ctxt("ctxt_str", ctxt_str, '0);
    send_string("a5", 0);
  endtask

  task automatic test_invalid_keys();
    apply_reset();
    key = make_key("ABCDEFGHIJKA");
    send_string("b", 0);
    compare_bit("err_invalid_key", err_invalid_key, 1'b1);
    compare_bit("key_not_installed", key_not_installed, 1'b1);
    key = make_key("ABCDEF-HIJKL");
    send_string("c9", 0);
    compare_bit("err_invalid_key", err_invalid_key, 1'b1);
    compare_bit("key_not_installed", key_not_installed, 1'b1);
    // twelve distinct characters when case counts
    key = make_key("aBcDeFAbCdEf");
    #16;
    compare_bit("err_invalid_key", err_invalid_key, 1'b0);
    check_cycle();
    @(posedge clk);
    #2;
    compare_bit("key_not_installed", key_not_installed, 1'b0);
  endtask

  task automatic test_install_encode();
    ctxt_t lower_pair;
    apply_reset();
    install_key("Q7wE3rT9yU1i");
    lower_pair = model_encode(m_table, "g");
    ptxt_char  = "g";
    ptxt_valid = 1'b1;
    #8;
    compare_ctxt("ctxt_str lower case", ctxt_str, lower_pair);
    ptxt_char  = "G";
    #8;
    compare_ctxt("ctxt_str upper case", ctxt_str, lower_pair);
    check_cycle();
    @(posedge clk);
    #2;
    send_string("aZ0m1N2b3Y4c5X6d7W8e9", 1);
  endtask

  task automatic test_rejected_input();
    apply_reset();
    install_key("k2L8pZ0qX5mN");
    send_string("#@[`{/:", 0);
    send_char("k", 1'b0, 0);
    send_string("kK", 1);
    send_char(8'h7f, 1'b1, 0);
    send_string("9", 1);
  endtask

  task automatic test_key_ignored();
    apply_reset();
    install_key("Q7wE3rT9yU1i");
    send_string("hello", 1);
    key = make_key("ZYXWVUTSRQPO");
    send_string("world42", 1);
    key = make_key("ZZZZ!!!!????");
    send_string("Again8", 1);
    compare_bit("key_not_installed", key_not_installed, 1'b0);
  endtask

  task automatic test_random_stream();
    string valid_set;
    char_t c;
    int    idx;
    valid_set = "ABCDEFGHIJKLMNOPQRSTUVWXYZabcdefghijklmnopqrstuvwxyz0123456789";
    apply_reset();
    install_key("m3N4b5V6c7X8");
    for (int n = 0; n < 200; n++) begin
      rng = lcg_next(rng);
      if (rng[3:0] < 4'd12) begin
        idx = int'(rng[15:8]) % 62;
        c   = valid_set[idx];
      end else begin
        c = rng[23:16];
      end
      send_char(c, rng[28], -1);
    end
    ptxt_valid = 1'b0;
  endtask

  initial begin
    clk        = 1'b0;
    rst_n      = 1'b0;
    ptxt_valid = 1'b0;
    ptxt_char  = '0;
    key        = '0;
    errors     = 0;
    checks     = 0;
    rng        = 32'hc11b_3016;
    test_reset_state();
    test_invalid_keys();
    test_install_encode();
    test_rejected_input();
    test_key_ignored();
    test_random_stream();
    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

// File: src/char_encoder.sv
//********************************************************************
// plaintext encoder: classifies the character, maps it to a table
// index and picks the row and column characters as ciphertext
//********************************************************************

module char_encoder (
  input  rst_pkg::char_t      ptxt_char,
  input  logic                ptxt_valid,
  input  rst_pkg::sub_table_t sub_table,
  input  logic                installed,
  output rst_pkg::ctxt_t      ctxt,
  output logic                ctxt_ready,
  output logic                err_invalid_ptxt_char
);

  import rst_pkg::*;

  char_class_e      cls;
  logic [IDX_W-1:0] idx;
  logic [SEL_W-1:0] row_sel;
  logic [SEL_W-1:0] col_sel;

  always_comb begin
    cls = char_class(ptxt_char);

    // letters 0..25 regardless of case, digits 26..35
    case (cls)
      CLASS_UPPER: idx = IDX_W'(ptxt_char - CHAR_UPPER_A);
      CLASS_LOWER: idx = IDX_W'(ptxt_char - CHAR_LOWER_A);
      CLASS_DIGIT: idx = IDX_W'(LETTER_COUNT) + IDX_W'(ptxt_char - CHAR_DIGIT_0);
      default:     idx = '0;
    endcase

    row_sel = SEL_W'(idx / IDX_W'(AXIS_LEN));
    col_sel = SEL_W'(idx % IDX_W'(AXIS_LEN));

    // flag follows the character even with ptxt_valid low
    err_invalid_ptxt_char = (cls == CLASS_INVALID);
    ctxt_ready = ptxt_valid && !err_invalid_ptxt_char && installed;

    ctxt = '0;
    if (ctxt_ready) begin
      ctxt.row = sub_table.rows[row_sel];
      ctxt.col = sub_table.cols[col_sel];
    end

    // index must stay inside the 6x6 table
    if (ctxt_ready) begin
      assert (idx < IDX_W'(AXIS_LEN * AXIS_LEN))
        else $error("char_encoder: index %0d outside the table", idx);
    end
  end

endmodule

// File: src/key_checker.sv
//********************************************************************
// key check: every character alphanumeric and all twelve distinct,
// case sensitive
//********************************************************************

module key_checker (
  input  rst_pkg::key_t key,
  output logic          key_valid
);

  import rst_pkg::*;

  logic all_alnum;
  logic dup_found;

  always_comb begin
    all_alnum = 1'b1;
    dup_found = 1'b0;

    for (int i = 0; i < KEY_LEN; i++) begin
      if (char_class(key[i]) == CLASS_INVALID) begin
        all_alnum = 1'b0;
      end
      // each pair compared once
      for (int j = i + 1; j < KEY_LEN; j++) begin
        if (key[i] == key[j]) begin
          dup_found = 1'b1;
        end
      end
    end

    key_valid = all_alnum && !dup_found;
  end

endmodule

// File: src/rot_table.sv
//********************************************************************
// substitution table: loads rows and columns from the first valid
// key after reset, then rotates both by one on every accepted char
//********************************************************************

module rot_table (
  input  logic                clk,
  input  logic                rst_n,
  input  rst_pkg::key_t       key,
  input  logic                key_valid,
  input  logic                accept,
  output rst_pkg::sub_table_t sub_table,
  output logic                installed
);

  import rst_pkg::*;

  table_state_e state;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state     <= TABLE_EMPTY;
      sub_table <= '0;
    end else begin
      case (state)
        TABLE_EMPTY: begin
          // key is taken once, later keys are ignored
          if (key_valid) begin
            for (int i = 0; i < AXIS_LEN; i++) begin
              sub_table.rows[i] <= key[INIT_ROW_SEL[i]];
              sub_table.cols[i] <= key[INIT_COL_SEL[i]];
            end
            state <= TABLE_READY;
          end
        end

        TABLE_READY: begin
          // row i moves to i+1, last row wraps to row 0
          if (accept) begin
            sub_table.rows <= {sub_table.rows[AXIS_LEN-2:0],
                               sub_table.rows[AXIS_LEN-1]};
            sub_table.cols <= {sub_table.cols[AXIS_LEN-2:0],
                               sub_table.cols[AXIS_LEN-1]};
          end
        end

        default: begin
          state <= TABLE_EMPTY;
        end
      endcase
    end
  end

  assign installed = (state == TABLE_READY);

  // encoder must not accept a character before the key is in
  a_no_accept_when_empty : assert property (
    @(posedge clk) disable iff (!rst_n)
    accept |-> (state == TABLE_READY)
  ) else $error("rot_table: accept while table empty");

  // installation is sticky until the next reset
  a_installed_sticky : assert property (
    @(posedge clk) disable iff (!rst_n)
    installed |=> installed
  ) else $error("rot_table: installed dropped without reset");

endmodule

// File: src/rst_cipher.sv
//********************************************************************
// cipher top level: key checker, rotating table and encoder, plus
// the two active-high error flags
//********************************************************************

module rst_cipher (
  input  logic           clk,
  input  logic           rst_n,
  input  logic           ptxt_valid,
  input  rst_pkg::key_t  key,
  input  rst_pkg::char_t ptxt_char,
  output rst_pkg::ctxt_t ctxt_str,
  output logic           ctxt_ready,
  output logic           err_invalid_ptxt_char,
  output logic           err_invalid_key,
  output logic           key_not_installed
);

  import rst_pkg::*;

  logic       key_valid;
  logic       installed;
  sub_table_t sub_table;

  key_checker u_key_checker (
    .key       (key),
    .key_valid (key_valid)
  );

  // accepted characters feed back to rotate the table
  rot_table u_rot_table (
    .clk       (clk),
    .rst_n     (rst_n),
    .key       (key),
    .key_valid (key_valid),
    .accept    (ctxt_ready),
    .sub_table (sub_table),
    .installed (installed)
  );

  char_encoder u_char_encoder (
    .ptxt_char             (ptxt_char),
    .ptxt_valid            (ptxt_valid),
    .sub_table             (sub_table),
    .installed             (installed),
    .ctxt                  (ctxt_str),
    .ctxt_ready            (ctxt_ready),
    .err_invalid_ptxt_char (err_invalid_ptxt_char)
  );

  assign err_invalid_key   = !key_valid;
  assign key_not_installed = !installed;

endmodule

// File: src/rst_pkg.sv
//********************************************************************
// shared types for the rotary substitution table cipher: characters,
// key, table and ciphertext structs, table states, key positions used
// at installation and the character classifier
//********************************************************************

package rst_pkg;

  typedef logic [7:0] char_t;

  localparam int KEY_LEN  = 12;
  localparam int AXIS_LEN = 6;

  // index widths derived from the table size
  localparam int KEY_IDX_W = $clog2(KEY_LEN);
  localparam int IDX_W     = $clog2(AXIS_LEN * AXIS_LEN);
  localparam int SEL_W     = $clog2(AXIS_LEN);

  typedef char_t [KEY_LEN-1:0] key_t;

  typedef enum logic [1:0] {
    CLASS_UPPER,
    CLASS_LOWER,
    CLASS_DIGIT,
    CLASS_INVALID
  } char_class_e;

  localparam char_t CHAR_UPPER_A = 8'h41;
  localparam char_t CHAR_UPPER_Z = 8'h5a;
  localparam char_t CHAR_LOWER_A = 8'h61;
  localparam char_t CHAR_LOWER_Z = 8'h7a;
  localparam char_t CHAR_DIGIT_0 = 8'h30;
  localparam char_t CHAR_DIGIT_9 = 8'h39;

  // digits follow the 26 letters in the index space
  localparam int LETTER_COUNT = 26;

  // key positions feeding rows 0..5 and columns 0..5, element 0 last
  localparam logic [AXIS_LEN-1:0][KEY_IDX_W-1:0] INIT_ROW_SEL =
    {4'd5, 4'd7, 4'd3, 4'd9, 4'd1, 4'd11};
  localparam logic [AXIS_LEN-1:0][KEY_IDX_W-1:0] INIT_COL_SEL =
    {4'd4, 4'd6, 4'd2, 4'd8, 4'd0, 4'd10};

  typedef struct packed {
    char_t [AXIS_LEN-1:0] rows;
    char_t [AXIS_LEN-1:0] cols;
  } sub_table_t;

  // row character in the upper byte
  typedef struct packed {
    char_t row;
    char_t col;
  } ctxt_t;

  typedef enum logic {
    TABLE_EMPTY,
    TABLE_READY
  } table_state_e;

  function automatic char_class_e char_class(input char_t c);
    if (c >= CHAR_UPPER_A && c <= CHAR_UPPER_Z) begin
      return CLASS_UPPER;
    end
    if (c >= CHAR_LOWER_A && c <= CHAR_LOWER_Z) begin
      return CLASS_LOWER;
    end
    if (c >= CHAR_DIGIT_0 && c <= CHAR_DIGIT_9) begin
      return CLASS_DIGIT;
    end
    return CLASS_INVALID;
  endfunction

endpackage

// File: vlog.f
+incdir+include
src/rst_pkg.sv
src/key_checker.sv
src/rot_table.sv
src/char_encoder.sv
src/rst_cipher.sv
bench/tb_rst_cipher.sv
